/* hdl/permPkg.sv */
package permPkg;

    localparam int varCount    = 4;
    localparam int mbfWidth    = 1 << varCount;   // 16 truth-table bits
    localparam int permCount   = 24;              // 4! variable orderings
    localparam int countWidth  = 5;               // coeffCount 0..24
    localparam int weightWidth = 5;               // popcount 0..16
    localparam int sumWidth    = 10;              // at most 24 * 16

    typedef logic [mbfWidth-1:0] mbf_t;

    typedef logic [1:0] varIdx_t;
    // entry k gives the new position of variable k
    typedef varIdx_t [varCount-1:0] permMap_t;

    // digits read as variable 3, 2, 1, 0 and the identity is the last entry
    localparam permMap_t permTable [permCount] = '{
        8'b00_01_10_11, 8'b00_01_11_10, 8'b00_10_01_11, 8'b00_10_11_01,
        8'b00_11_01_10, 8'b00_11_10_01, 8'b01_00_10_11, 8'b01_00_11_10,
        8'b01_10_00_11, 8'b01_10_11_00, 8'b01_11_00_10, 8'b01_11_10_00,
        8'b10_00_01_11, 8'b10_00_11_01, 8'b10_01_00_11, 8'b10_01_11_00,
        8'b10_11_00_01, 8'b10_11_01_00, 8'b11_00_01_10, 8'b11_00_10_01,
        8'b11_01_00_10, 8'b11_01_10_00, 8'b11_10_00_01, 8'b11_10_01_00
    };

    // stream item, either a new top or a bottom to evaluate
    typedef struct packed {
        logic newTop;
        mbf_t mbf;
    } inItem_t;

    // one permuted copy of a bottom
    typedef struct packed {
        mbf_t top;
        mbf_t permBot;
        logic first;
        logic last;
    } permWork_t;

    typedef struct packed {
        logic                   hit;      // permuted bottom lies under top
        logic [weightWidth-1:0] weight;   // popcount of top minus bottom
        logic                   first;
        logic                   last;
    } evalOut_t;

    typedef struct packed {
        logic [countWidth-1:0] coeffCount;
        logic [sumWidth-1:0]   summedData;
    } result_t;

endpackage

/* hdl/streamFifo.sv */
module streamFifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 4
) (
    input  logic     clock,
    input  logic     rst,
    input  logic     writeEn,
    input  payload_t writeData,
    output logic     full,
    input  logic     readEn,
    output payload_t readData,
    output logic     empty
);

    localparam int ptrWidth   = (depth > 1) ? $clog2(depth) : 1;
    localparam int countWidth = $clog2(depth + 1);

    payload_t mem [depth];
    logic [ptrWidth-1:0]   wrPtr;
    logic [ptrWidth-1:0]   rdPtr;
    logic [countWidth-1:0] count;
    logic [countWidth-1:0] countNext;
    logic doWrite;
    logic doRead;

    assign doRead  = readEn && !empty;
    assign doWrite = writeEn && (!full || doRead);   // full slot frees up this cycle
    assign readData = mem[rdPtr];                     // first-word fall-through

    always_comb begin
        countNext = count;
        if (doWrite && !doRead) countNext = count + 1'b1;
        if (doRead && !doWrite) countNext = count - 1'b1;
    end

    always_ff @(posedge clock) begin
        if (doWrite) mem[wrPtr] <= writeData;
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            full  <= 1'b1;   // no space offered until out of reset
            empty <= 1'b1;
        end else begin
            if (doWrite) wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;
            if (doRead) rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
            count <= countNext;
            full  <= (countNext == countWidth'(depth));
            empty <= (countNext == '0);
        end
    end

endmodule

/* hdl/permutationIterator.sv */
module permutationIterator #(
    parameter int credits = 4
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               headValid,
    input  permPkg::inItem_t   headItem,
    output logic               take,
    input  logic               resultTaken,
    output logic               workValid,
    output permPkg::permWork_t work
);
    import permPkg::*;

    localparam int creditWidth = $clog2(credits + 1);
    localparam int idxWidth    = $clog2(permCount);

    mbf_t topReg;    // top for bottoms taken from now on
    mbf_t workTop;   // top that was in force when the current bottom was taken
    mbf_t botReg;
    logic [idxWidth-1:0]    permIdx;
    logic                   busy;
    logic [creditWidth-1:0] creditCount;
    logic lastPerm;
    logic canTakeBot;
    logic takeBot;

    // bit i moves to the index whose variable bits follow the mapping
    function automatic mbf_t permuteMbf(mbf_t src, permMap_t map);
        mbf_t dst;
        logic [varCount-1:0] srcIdx;
        logic [varCount-1:0] dstIdx;
        dst = '0;
        for (int i = 0; i < mbfWidth; i++) begin
            srcIdx = varCount'(i);
            dstIdx = '0;
            for (int k = 0; k < varCount; k++) begin
                dstIdx[map[k]] = srcIdx[k];
            end
            dst[dstIdx] = src[i];
        end
        return dst;
    endfunction

    assign lastPerm   = busy && (permIdx == idxWidth'(permCount - 1));
    // a new bottom may follow straight on from the last permutation
    assign canTakeBot = (!busy || lastPerm) && (creditCount != '0);
    assign take       = headValid && (headItem.newTop || canTakeBot);
    assign takeBot    = take && !headItem.newTop;

    always_ff @(posedge clock) begin
        if (!rst) begin
            topReg <= '0;
        end else if (take && headItem.newTop) begin
            topReg <= headItem.mbf;
        end
    end

    always_ff @(posedge clock) begin
        if (takeBot) begin
            botReg  <= headItem.mbf;
            workTop <= topReg;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            busy      <= 1'b0;
            permIdx   <= '0;
            workValid <= 1'b0;
        end else begin
            workValid <= busy;
            if (takeBot) begin
                busy    <= 1'b1;
                permIdx <= '0;
            end else if (lastPerm) begin
                busy    <= 1'b0;
                permIdx <= '0;
            end else if (busy) begin
                permIdx <= permIdx + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (busy) begin
            work.top     <= workTop;
            work.permBot <= permuteMbf(botReg, permTable[permIdx]);
            work.first   <= (permIdx == '0);
            work.last    <= lastPerm;
        end
    end

    // one credit per free slot in the result FIFO
    always_ff @(posedge clock) begin
        if (!rst) begin
            creditCount <= creditWidth'(credits);
        end else begin
            case ({takeBot, resultTaken})
                2'b10:   creditCount <= creditCount - 1'b1;
                2'b01:   creditCount <= creditCount + 1'b1;
                default: creditCount <= creditCount;
            endcase
        end
    end

endmodule

/* hdl/permutationEvaluator.sv */
module permutationEvaluator (
    input  logic               clock,
    input  logic               rst,
    input  logic               workValid,
    input  permPkg::permWork_t work,
    output logic               evalValid,
    output permPkg::evalOut_t  evalOut
);
    import permPkg::*;

    typedef struct packed {
        logic hit;
        mbf_t mask;   // top with the permuted bottom removed
        logic first;
        logic last;
    } stage1_t;

    stage1_t s1;
    logic    s1Valid;

    function automatic logic [weightWidth-1:0] popCount(mbf_t bits);
        logic [weightWidth-1:0] total;
        total = '0;
        for (int i = 0; i < mbfWidth; i++) begin
            total = total + weightWidth'(bits[i]);
        end
        return total;
    endfunction

    always_ff @(posedge clock) begin
        if (!rst) begin
            s1Valid   <= 1'b0;
            evalValid <= 1'b0;
        end else begin
            s1Valid   <= workValid;
            evalValid <= s1Valid;
        end
    end

    // stage 1: subset test and difference mask
    always_ff @(posedge clock) begin
        if (workValid) begin
            s1.hit   <= ((work.permBot & ~work.top) == '0);
            s1.mask  <= work.top & ~work.permBot;
            s1.first <= work.first;
            s1.last  <= work.last;
        end
    end

    // stage 2: weight of the mask
    always_ff @(posedge clock) begin
        if (s1Valid) begin
            evalOut.hit    <= s1.hit;
            evalOut.weight <= popCount(s1.mask);
            evalOut.first  <= s1.first;
            evalOut.last   <= s1.last;
        end
    end

endmodule

/* hdl/coefficientAccumulator.sv */
module coefficientAccumulator (
    input  logic              clock,
    input  logic              rst,
    input  logic              evalValid,
    input  permPkg::evalOut_t evalOut,
    output logic              resValid,
    output permPkg::result_t  result
);
    import permPkg::*;

    logic [countWidth-1:0] countAcc;
    logic [sumWidth-1:0]   sumAcc;
    logic [countWidth-1:0] countNext;
    logic [sumWidth-1:0]   sumNext;

    // a first entry starts a fresh bottom, dropping the previous totals
    always_comb begin
        countNext = evalOut.first ? '0 : countAcc;
        sumNext   = evalOut.first ? '0 : sumAcc;
        if (evalOut.hit) begin
            countNext = countNext + 1'b1;
            sumNext   = sumNext + sumWidth'(evalOut.weight);
        end
    end

    always_ff @(posedge clock) begin
        if (evalValid) begin
            countAcc <= countNext;
            sumAcc   <= sumNext;
        end
    end

    always_ff @(posedge clock) begin
        if (evalValid && evalOut.last) begin
            result.coeffCount <= countNext;
            result.summedData <= sumNext;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= evalValid && evalOut.last;   // single-cycle pulse
        end
    end

endmodule

/* hdl/permutePipeline.sv */
module permutePipeline #(
    parameter int inDepth  = 4,
    parameter int outDepth = 4
) (
    input  logic             clock,
    input  logic             rst,
    input  logic             inValid,
    output logic             inReady,
    input  permPkg::inItem_t inItem,
    output logic             outValid,
    input  logic             outReady,
    output permPkg::result_t outResult
);
    import permPkg::*;

    inItem_t   headItem;
    logic      inFull;
    logic      inEmpty;
    logic      take;
    logic      resultTaken;
    logic      workValid;
    permWork_t work;
    logic      evalValid;
    evalOut_t  evalOut;
    logic      resValid;
    result_t   result;
    logic      resFull;    // watched by the bound checks
    logic      resEmpty;

    assign inReady     = !inFull;
    assign outValid    = !resEmpty;
    assign resultTaken = outValid && outReady;   // frees one credit

    streamFifo #(
        .payload_t(inItem_t),
        .depth    (inDepth)
    ) inFifo (
        .clock    (clock),
        .rst      (rst),
        .writeEn  (inValid && inReady),   // only a completed input handshake
        .writeData(inItem),
        .full     (inFull),
        .readEn   (take),
        .readData (headItem),
        .empty    (inEmpty)
    );

    permutationIterator #(
        .credits(outDepth)
    ) iterator (
        .clock      (clock),
        .rst        (rst),
        .headValid  (!inEmpty),
        .headItem   (headItem),
        .take       (take),
        .resultTaken(resultTaken),
        .workValid  (workValid),
        .work       (work)
    );

    permutationEvaluator evaluator (
        .clock    (clock),
        .rst      (rst),
        .workValid(workValid),
        .work     (work),
        .evalValid(evalValid),
        .evalOut  (evalOut)
    );

    coefficientAccumulator accumulator (
        .clock    (clock),
        .rst      (rst),
        .evalValid(evalValid),
        .evalOut  (evalOut),
        .resValid (resValid),
        .result   (result)
    );

    // sized by the credits so it never overflows
    streamFifo #(
        .payload_t(result_t),
        .depth    (outDepth)
    ) outFifo (
        .clock    (clock),
        .rst      (rst),
        .writeEn  (resValid),
        .writeData(result),
        .full     (resFull),
        .readEn   (outReady),
        .readData (outResult),
        .empty    (resEmpty)
    );

endmodule

/* dv/permutePipeline_props.sv */
module permutePipelineProps (
    input logic             clock,
    input logic             rst,
    input logic             inReady,
    input logic             outValid,
    input logic             outReady,
    input permPkg::result_t outResult,
    input logic             resValid,
    input logic             resFull
);
    timeunit 1ns;
    timeprecision 100ps;

    // a stalled result keeps its value
    holdWhileStalled: assert property (@(posedge clock) disable iff (!rst)
        outValid && !outReady |=> $stable(outResult))
        else $error("outResult changed while the output was stalled");

    quietInReset: assert property (@(posedge clock)
        !rst |=> !inReady && !outValid)
        else $error("inReady or outValid high during reset");

    // credits keep the result FIFO from overflowing
    noOverflow: assert property (@(posedge clock) disable iff (!rst)
        !(resValid && resFull))
        else $error("result written while the result FIFO was full");

endmodule

bind permutePipeline permutePipelineProps props_i (
    .clock    (clock),
    .rst      (rst),
    .inReady  (inReady),
    .outValid (outValid),
    .outReady (outReady),
    .outResult(outResult),
    .resValid (resValid),
    .resFull  (resFull)
);

/* dv/permutePipelineTb.sv */
module permutePipelineTb;
    timeunit 1ns;
    timeprecision 100ps;
    import permPkg::*;

    localparam int itemCount     = 200;
    localparam int timeoutCycles = itemCount * 30 * 4;

    logic    clock;
    logic    rst;
    logic    inValid;
    logic    inReady;
    inItem_t inItem;
    logic    outValid;
    logic    outReady;
    result_t outResult;

    result_t expected [$];   // results still owed, oldest first
    mbf_t    genTop;         // top the generator draws bottoms from
    mbf_t    modelTop;       // top in force at the input handshake
    logic    haveItem;
    logic    sawInFull;
    int      made;
    int      bottomsSent;
    int      received;
    int      stallLeft;
    int      cycles;

    permutePipeline #(
        .inDepth (4),
        .outDepth(4)
    ) permutePipeline_i (
        .clock    (clock),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inItem   (inItem),
        .outValid (outValid),
        .outReady (outReady),
        .outResult(outResult)
    );

    always #5 clock = ~clock;

    task automatic abortRun(string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkResult(result_t want, result_t got);
        if (got.coeffCount !== want.coeffCount) begin
            abortRun($sformatf("[FAIL] coeffCount expected 0x%h got 0x%h",
                               want.coeffCount, got.coeffCount));
        end else if (got.summedData !== want.summedData) begin
            abortRun($sformatf("[FAIL] summedData expected 0x%h got 0x%h",
                               want.summedData, got.summedData));
        end
    endtask

    // variable k of the source index lands on position map[k]
    function automatic mbf_t permuteBits(mbf_t src, permMap_t map);
        mbf_t dst;
        int   target;
        dst = '0;
        for (int i = 0; i < mbfWidth; i++) begin
            target = 0;
            for (int k = 0; k < varCount; k++) begin
                if (i[k]) target += 1 << map[k];
            end
            dst[target] = src[i];
        end
        return dst;
    endfunction

    function automatic result_t expectedResult(mbf_t top, mbf_t bot);
        result_t r;
        mbf_t    moved;
        r = '0;
        for (int p = 0; p < permCount; p++) begin
            moved = permuteBits(bot, permTable[p]);
            if ((moved & ~top) == '0) begin   // permuted bottom fits under top
                r.coeffCount = r.coeffCount + 1'b1;
                r.summedData = r.summedData + sumWidth'($countones(top & ~moved));
            end
        end
        return r;
    endfunction

    // every subset of a set point is set too, giving a monotone function
    function automatic mbf_t closeDown(mbf_t raw);
        mbf_t closed;
        closed = '0;
        for (int i = 0; i < mbfWidth; i++) begin
            if (raw[i]) begin
                for (int j = 0; j < mbfWidth; j++) begin
                    if ((j & ~i) == 0) closed[j] = 1'b1;
                end
            end
        end
        return closed;
    endfunction

    task automatic makeItem();
        int pick;
        pick = $urandom_range(0, 15);
        inItem.newTop = (made == 0) || (pick < 2);   // about one top in eight
        if (inItem.newTop) begin
            // sparse seed points, else the closure is nearly always full
            genTop     = closeDown(mbf_t'($urandom & $urandom & $urandom));
            inItem.mbf = genTop;
        end else if (pick == 2) begin
            inItem.mbf = '0;
        end else if (pick == 3) begin
            inItem.mbf = genTop;
        end else begin
            inItem.mbf = genTop & mbf_t'($urandom);
        end
        made++;
        haveItem = 1'b1;
    endtask

    task automatic acceptItem();
        if (inItem.newTop) begin
            modelTop = inItem.mbf;
        end else begin
            expected.push_back(expectedResult(modelTop, inItem.mbf));
            bottomsSent++;
        end
        haveItem = 1'b0;
    endtask

    task automatic takeResult();
        if (expected.size() == 0) abortRun("result handed out with no bottom outstanding");
        checkResult(expected.pop_front(), outResult);
        received++;
    endtask

    task automatic driveInputs();
        if (!haveItem && made < itemCount) makeItem();
        inValid = haveItem && ($urandom_range(0, 9) < 7);
        if (stallLeft > 0) begin
            stallLeft--;
            outReady = 1'b0;
        end else if ($urandom_range(0, 99) == 0) begin
            stallLeft = $urandom_range(60, 150);   // long enough to use up the credits
            outReady  = 1'b0;
        end else begin
            outReady = ($urandom_range(0, 3) != 0);
        end
    endtask

    initial begin
        clock       = 1'b0;
        rst         = 1'b0;
        inValid     = 1'b0;
        inItem      = '0;
        outReady    = 1'b0;
        haveItem    = 1'b0;
        sawInFull   = 1'b0;
        genTop      = '0;
        modelTop    = '0;
        made        = 0;
        bottomsSent = 0;
        received    = 0;
        stallLeft   = 0;
        cycles      = 0;
        void'($urandom(30612));

        repeat (3) begin
            @(posedge clock);
            #1;
            if (inReady || outValid) abortRun("inReady or outValid high during reset");
        end
        rst = 1'b1;
        driveInputs();

        // handshakes are read at the falling edge, where all signals are settled
        while (made < itemCount || haveItem || received < bottomsSent) begin
            @(negedge clock);
            cycles++;
            if (cycles > timeoutCycles) abortRun("timeout waiting for results to drain");
            if (!inReady && cycles > 2) sawInFull = 1'b1;
            if (inValid && inReady) acceptItem();
            if (outValid && outReady) takeResult();
            @(posedge clock);
            #1;
            driveInputs();
        end

        @(posedge clock);
        #1;
        inValid  = 1'b0;
        outReady = 1'b1;
        repeat (40) begin
            @(negedge clock);
            if (outValid) abortRun("extra result after every bottom was answered");
        end

        if (!sawInFull) begin
            abortRun("inReady never dropped during output stalls");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

/* list.f */
hdl/permPkg.sv
hdl/streamFifo.sv
hdl/permutationIterator.sv
hdl/permutationEvaluator.sv
hdl/coefficientAccumulator.sv
hdl/permutePipeline.sv
dv/permutePipeline_props.sv
dv/permutePipelineTb.sv

/* run.sh */
#!/bin/sh
# build and run the permutePipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module permutePipelineTb \
    -Mdir obj_dir -o permutePipelineSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/permutePipelineSim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
